/* fetch_unit.f */
verilog/fetch_pkg.sv
verilog/fetch_control.sv
verilog/instruction_cache.sv
verilog/burst_reader.sv
verilog/fetch_unit.sv
testbench/fetch_memory_model.sv
testbench/fetch_unit_tb.sv

/* testbench/fetch_memory_model.sv */
`default_nettype none

module fetch_memory_model (
	input logic clock,
	input logic reset,
	input logic [31:0] araddr,
	input logic [1:0] arburst,
	input logic [3:0] arlen,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic rlast,
	output logic rvalid,
	input logic rready
);
	// every word is a pattern of its own address, so a misplaced beat shows up at once
	localparam logic [31:0] WORD_KEY = 32'h1357_9BDF;

	integer seed = 20;

	task automatic wait_cycles(input int count);
		repeat (count) begin
			@(posedge clock);
			#2;
		end
	endtask

	function automatic int random_delay();
		return $random(seed) & 3;
	endfunction

	// one read is served at a time, with random gaps before arready and before each beat
	initial begin : serve_reads
		logic [31:0] address;
		logic incrementing;
		int beats;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		forever begin
			wait_cycles(1);
			if (!reset && arvalid) begin
				wait_cycles(random_delay());
				arready = 1'b1;
				address = araddr;
				// 2'b01 is the incrementing burst on this bus
				incrementing = (arburst == 2'b01);
				beats = arlen + 1;
				wait_cycles(1);
				arready = 1'b0;
				for (int beat = 0; beat < beats; beat++) begin
					wait_cycles(random_delay());
					rdata = address ^ WORD_KEY;
					rlast = (beat == beats - 1);
					rvalid = 1'b1;
					// a beat stays on the bus until the reader takes it
					@(posedge clock);
					while (!rready) @(posedge clock);
					#2;
					rvalid = 1'b0;
					rlast = 1'b0;
					if (incrementing) address = address + 32'd4;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/fetch_unit_tb.sv */
`default_nettype none

module fetch_unit_tb;
	import fetch_pkg::*;

	localparam int CLOCK_PERIOD = 20;
	localparam logic [31:0] RESET_PC = 32'h3000_0000;
	localparam logic [31:0] CACHED_BASE = 32'hA000_0000;
	localparam logic [31:0] CACHED_LIMIT = 32'hA200_0000;
	localparam logic [31:0] WORD_KEY = 32'h1357_9BDF;
	localparam int PASS_WORDS = 24;
	// reset 1, uncached 11, two cached passes, back-pressure 16, redirects 48
	localparam int PLANNED_FETCHES = 1 + 11 + 2 * PASS_WORDS + 16 + 48;

	logic clock;
	logic reset;
	logic redirect;
	logic [31:0] redirect_pc;
	fetch_packet_t packet;
	logic out_valid;
	logic out_ready;
	logic [31:0] araddr;
	logic [1:0] arburst;
	logic [3:0] arlen;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic rlast;
	logic rvalid;
	logic rready;

	integer seed = 20;
	int error_count = 0;
	int tests_run = 0;
	int packet_count = 0;
	int request_count = 0;
	logic [31:0] expected_pc;
	logic first_packet;
	logic transfer;

	logic hold_ready = 1'b0;
	logic sparse_ready = 1'b0;
	logic random_redirects = 1'b0;
	logic redirect_now = 1'b0;
	logic [31:0] redirect_target = '0;
	logic check_request_pc = 1'b1;
	logic quiet_bus = 1'b0;

	fetch_unit #(
		.RESET_PC(RESET_PC),
		.CACHED_BASE(CACHED_BASE),
		.CACHED_LIMIT(CACHED_LIMIT),
		.CACHE_LINES(16)
	) DUT (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.packet(packet),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.araddr(araddr),
		.arburst(arburst),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready)
	);

	fetch_memory_model memory (
		.clock(clock),
		.reset(reset),
		.araddr(araddr),
		.arburst(arburst),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	function automatic logic cacheable(input logic [31:0] address);
		return (address >= CACHED_BASE) && (address < CACHED_LIMIT);
	endfunction

	// a quarter of the targets land outside the window, the rest spread over 32 lines
	function automatic logic [31:0] random_target();
		logic [31:0] bits;
		bits = $random(seed);
		if (bits[31:30] == 2'b00) begin
			return 32'h3000_2000 + (bits & 32'h0000_00FC);
		end
		return CACHED_BASE + (bits & 32'h0000_01FC);
	endfunction

	task automatic report_error(input string message);
		error_count++;
		$display("ERROR at time %0t: %s", $time, message);
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic wait_packets(input int count);
		int target;
		target = packet_count + count;
		while (packet_count < target) next_cycle();
	endtask

	// decode holds off until a packet waits in deliver, then the redirect drops it
	task automatic redirect_when_held(input logic [31:0] target);
		hold_ready = 1'b1;
		next_cycle();
		while (!out_valid) next_cycle();
		redirect_target = target;
		redirect_now = 1'b1;
		next_cycle();
		hold_ready = 1'b0;
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (error_count == start_errors) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, error_count - start_errors);
		end
	endtask

	// redirect always goes out with out_ready low, so it never meets a transfer
	initial begin : drive_decode_side
		redirect = 1'b0;
		redirect_pc = '0;
		out_ready = 1'b0;
		forever begin
			@(posedge clock);
			#2;
			redirect = 1'b0;
			if (redirect_now) begin
				redirect_pc = redirect_target;
				redirect = 1'b1;
				out_ready = 1'b0;
				redirect_now = 1'b0;
			end else if (random_redirects && ($random(seed) & 31) == 0) begin
				redirect_pc = random_target();
				redirect = 1'b1;
				out_ready = 1'b0;
			end else if (hold_ready) begin
				out_ready = 1'b0;
			end else if (sparse_ready) begin
				out_ready = ($random(seed) & 3) == 0;
			end else begin
				out_ready = ($random(seed) & 3) != 0;
			end
		end
	end

	assign transfer = out_valid && out_ready && !redirect;

	always @(posedge clock) begin
		if (reset) begin
			expected_pc <= RESET_PC;
			first_packet <= 1'b1;
		end else if (redirect) begin
			expected_pc <= redirect_pc;
		end else if (transfer) begin
			expected_pc <= expected_pc + 32'd4;
			first_packet <= 1'b0;
			packet_count <= packet_count + 1;
		end
		if (!reset && arvalid && arready) begin
			request_count <= request_count + 1;
		end
	end

	// the reset is synchronous, so the outputs are settled from the second reset edge on
	reset_quiet: assert property (@(posedge clock)
		reset && $past(reset) |-> !out_valid && !arvalid)
		else report_error("out_valid or arvalid high during reset");

	after_reset_quiet: assert property (@(posedge clock)
		$fell(reset) |-> !out_valid && !arvalid)
		else report_error("out_valid or arvalid high in the first cycle after reset");

	first_pc: assert property (@(posedge clock) disable iff (reset)
		transfer && first_packet |-> packet.pc == RESET_PC)
		else report_error($sformatf("first packet pc %h, expected %h",
			$sampled(packet.pc), RESET_PC));

	pc_order: assert property (@(posedge clock) disable iff (reset)
		transfer |-> packet.pc == expected_pc)
		else report_error($sformatf("packet pc %h, expected %h",
			$sampled(packet.pc), $sampled(expected_pc)));

	instruction_word: assert property (@(posedge clock) disable iff (reset)
		transfer |-> packet.instruction == (packet.pc ^ WORD_KEY))
		else report_error($sformatf("instruction %h at pc %h, expected %h",
			$sampled(packet.instruction), $sampled(packet.pc),
			$sampled(packet.pc) ^ WORD_KEY));

	packet_held: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !redirect |=> out_valid && $stable(packet))
		else report_error("packet changed or vanished while out_ready was low");

	address_held: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else report_error("read address changed before arready");

	ready_tied: assert property (@(posedge clock) disable iff (reset) rready)
		else report_error("rready low, so returned beats could be lost");

	line_request: assert property (@(posedge clock) disable iff (reset)
		arvalid && arready && cacheable(araddr)
		|-> arburst == burst_incrementing && arlen == 4'd3 && araddr[3:0] == 4'h0)
		else report_error($sformatf("line request at %h with burst %0d, length %0d",
			$sampled(araddr), $sampled(arburst), $sampled(arlen)));

	single_request: assert property (@(posedge clock) disable iff (reset)
		arvalid && arready && !cacheable(araddr) |-> arburst == burst_single && arlen == 4'd0)
		else report_error($sformatf("uncached request at %h with burst %0d, length %0d",
			$sampled(araddr), $sampled(arburst), $sampled(arlen)));

	single_address: assert property (@(posedge clock) disable iff (reset)
		arvalid && arready && !cacheable(araddr) && check_request_pc |-> araddr == expected_pc)
		else report_error($sformatf("uncached request at %h, expected %h",
			$sampled(araddr), $sampled(expected_pc)));

	no_refill: assert property (@(posedge clock) disable iff (reset) quiet_bus |-> !arvalid)
		else report_error($sformatf("bus request at %h on a line already cached",
			$sampled(araddr)));

	initial begin : run_tests
		int start_errors;
		int start_requests;
		reset = 1'b1;
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;

		start_errors = error_count;
		wait_packets(1);
		report_test("reset", start_errors);

		start_errors = error_count;
		wait_packets(11);
		report_test("uncached sequential fetch", start_errors);

		start_errors = error_count;
		redirect_when_held(CACHED_BASE);
		start_requests = request_count;
		wait_packets(PASS_WORDS);
		lines_requested: assert (request_count - start_requests == PASS_WORDS / 4)
			else report_error($sformatf("first pass requested %0d lines, expected %0d",
				request_count - start_requests, PASS_WORDS / 4));
		redirect_when_held(CACHED_BASE);
		quiet_bus = 1'b1;
		wait_packets(PASS_WORDS);
		quiet_bus = 1'b0;
		report_test("cached fetch", start_errors);

		start_errors = error_count;
		redirect_when_held(32'h3000_1000);
		sparse_ready = 1'b1;
		wait_packets(16);
		sparse_ready = 1'b0;
		report_test("back-pressure", start_errors);

		// a redirect during a fetch leaves its request address for the old pc
		start_errors = error_count;
		check_request_pc = 1'b0;
		random_redirects = 1'b1;
		wait_packets(48);
		random_redirects = 1'b0;
		report_test("random redirects", start_errors);

		$display("tests %0d, packets %0d, bus requests %0d, errors %0d",
			tests_run, packet_count, request_count, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		#(PLANNED_FETCHES * 40 * CLOCK_PERIOD);
		$display("timeout: only %0d packets arrived in the time for %0d fetches",
			packet_count, PLANNED_FETCHES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/burst_reader.sv */
`default_nettype none

module burst_reader (
	input logic clock,
	input logic reset,
	input logic request_valid,
	input fetch_pkg::bus_read_request_t request,
	output logic request_taken,
	output logic [31:0] araddr,
	output logic [1:0] arburst,
	output logic [3:0] arlen,
	output logic arvalid,
	input logic arready,
	input logic [31:0] rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready,
	output logic fill_valid,
	output fetch_pkg::cache_fill_t fill
);
	import fetch_pkg::*;

	bus_read_request_t active_request;
	logic active;
	logic [3:0] beat_count;
	logic start;

	assign start = request_valid && !active;
	assign request_taken = arvalid && arready;
	assign araddr = active_request.address;
	assign arburst = active_request.burst;
	assign arlen = active_request.length;
	assign rready = 1'b1;

	// the fill port sits here with the data channel it comes from
	assign fill_valid = rvalid && active;
	assign fill = '{address: active_request.address
			+ (active_request.burst == burst_incrementing ? {26'd0, beat_count, 2'b00} : 32'd0),
		data: rdata,
		last: rlast};

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			arvalid <= 1'b0;
			beat_count <= '0;
		end else begin
			if (start) begin
				active <= 1'b1;
				arvalid <= 1'b1;
				active_request <= request;
				beat_count <= '0;
			end else begin
				if (arvalid && arready) arvalid <= 1'b0;
				if (fill_valid) begin
					beat_count <= beat_count + 4'd1;
					if (rlast) active <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/fetch_control.sv */
`default_nettype none

module fetch_control #(
	parameter logic [31:0] RESET_PC = 32'h3000_0000,
	parameter logic [31:0] CACHED_BASE = 32'hA000_0000,
	parameter logic [31:0] CACHED_LIMIT = 32'hA200_0000
) (
	input logic clock,
	input logic reset,
	input logic redirect,
	input logic [31:0] redirect_pc,
	output logic lookup,
	output logic [31:0] lookup_pc,
	input logic hit,
	input logic [31:0] cache_word,
	output logic request_valid,
	output fetch_pkg::bus_read_request_t request,
	input logic request_taken,
	input logic fill_valid,
	input fetch_pkg::cache_fill_t fill,
	output fetch_pkg::fetch_packet_t packet,
	output logic out_valid,
	input logic out_ready
);
	import fetch_pkg::*;

	fetch_state_t state;
	fetch_state_t state_next;
	logic [31:0] pc;
	logic [31:0] pc_next;
	logic lookup_sent;
	logic redirect_pending;
	logic [31:0] pending_pc;
	logic [31:0] held_word;
	logic in_flight;
	logic fetch_done;
	logic [31:0] fetch_word;
	logic drop;
	logic [31:0] restart_pc;
	logic beat_matches;

	function automatic logic in_window(input logic [31:0] address);
		return (address >= CACHED_BASE) && (address < CACHED_LIMIT);
	endfunction

	function automatic fetch_state_t first_state(input logic [31:0] address);
		return in_window(address) ? state_lookup : state_uncached_request;
	endfunction

	assign lookup_pc = pc;
	assign lookup = (state == state_lookup) && !lookup_sent;
	assign out_valid = (state == state_deliver);
	assign request_valid = (state == state_miss_request) || (state == state_uncached_request);
	assign in_flight = (state != state_idle) && (state != state_deliver);
	assign beat_matches = fill_valid && (fill.address == pc);

	// the result of a fetch is thrown away if a redirect came in while it ran
	assign drop = redirect || redirect_pending;
	assign restart_pc = redirect ? redirect_pc : pending_pc;

	// a miss fetches the whole aligned line, anything outside the window one word
	always_comb begin
		if (in_window(pc)) begin
			request = '{address: pc & ~32'(LINE_WORDS * 4 - 1),
				burst: burst_incrementing,
				length: 4'(LINE_WORDS - 1)};
		end else begin
			request = '{address: pc, burst: burst_single, length: 4'd0};
		end
	end

	always_comb begin
		fetch_done = 1'b0;
		fetch_word = cache_word;
		case (state)
			state_lookup: fetch_done = lookup_sent && hit;
			state_refill: begin
				fetch_done = fill_valid && fill.last;
				fetch_word = beat_matches ? fill.data : held_word;
			end
			state_uncached_wait: begin
				fetch_done = fill_valid;
				fetch_word = fill.data;
			end
			default: ;
		endcase
	end

	always_comb begin
		state_next = state;
		pc_next = pc;
		case (state)
			state_idle: begin
				pc_next = redirect ? redirect_pc : pc;
				state_next = first_state(pc_next);
			end
			state_lookup: if (lookup_sent && !hit) state_next = state_miss_request;
			state_miss_request: if (request_taken) state_next = state_refill;
			state_uncached_request: if (request_taken) state_next = state_uncached_wait;
			state_deliver: begin
				if (redirect) begin
					pc_next = redirect_pc;
					state_next = first_state(redirect_pc);
				end else if (out_ready) begin
					pc_next = pc + 32'd4;
					state_next = first_state(pc + 32'd4);
				end
			end
			default: ;
		endcase
		if (fetch_done) begin
			if (drop) begin
				pc_next = restart_pc;
				state_next = first_state(restart_pc);
			end else begin
				state_next = state_deliver;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_idle;
			pc <= RESET_PC;
			lookup_sent <= 1'b0;
			redirect_pending <= 1'b0;
		end else begin
			state <= state_next;
			pc <= pc_next;
			lookup_sent <= lookup;
			if (fetch_done) begin
				redirect_pending <= 1'b0;
			end else if (redirect && in_flight) begin
				redirect_pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (redirect && in_flight && !fetch_done) begin
			pending_pc <= redirect_pc;
		end
		// the wanted word may arrive before the last beat of the line
		if (state == state_refill && beat_matches) begin
			held_word <= fill.data;
		end
		if (fetch_done && !drop) begin
			packet <= '{pc: pc, instruction: fetch_word};
		end
	end

endmodule

`default_nettype wire

/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// number of 32-bit words in one instruction cache line
	localparam int LINE_WORDS = 4;

	typedef enum logic [2:0] {
		state_idle,
		state_lookup,
		state_miss_request,
		state_refill,
		state_uncached_request,
		state_uncached_wait,
		state_deliver
	} fetch_state_t;

	// values follow the bus encoding of arburst
	typedef enum logic [1:0] {
		burst_single = 2'b00,
		burst_incrementing = 2'b01
	} burst_kind_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instruction;
	} fetch_packet_t;

	typedef struct packed {
		logic [31:0] address;
		burst_kind_t burst;
		logic [3:0] length;
	} bus_read_request_t;

	typedef struct packed {
		logic [31:0] address;
		logic [31:0] data;
		logic last;
	} cache_fill_t;

endpackage

`default_nettype wire

/* verilog/fetch_unit.sv */
`default_nettype none

module fetch_unit #(
	parameter logic [31:0] RESET_PC = 32'h3000_0000,
	parameter logic [31:0] CACHED_BASE = 32'hA000_0000,
	parameter logic [31:0] CACHED_LIMIT = 32'hA200_0000,
	parameter int CACHE_LINES = 16
) (
	input logic clock,
	input logic reset,
	input logic redirect,
	input logic [31:0] redirect_pc,
	output fetch_pkg::fetch_packet_t packet,
	output logic out_valid,
	input logic out_ready,
	output logic [31:0] araddr,
	output logic [1:0] arburst,
	output logic [3:0] arlen,
	output logic arvalid,
	input logic arready,
	input logic [31:0] rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready
);
	import fetch_pkg::*;

	logic lookup;
	logic [31:0] lookup_pc;
	logic hit;
	logic [31:0] cache_word;
	logic request_valid;
	bus_read_request_t request;
	logic request_taken;
	logic fill_valid;
	cache_fill_t fill;

	fetch_control #(
		.RESET_PC(RESET_PC),
		.CACHED_BASE(CACHED_BASE),
		.CACHED_LIMIT(CACHED_LIMIT)
	) control (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.lookup(lookup),
		.lookup_pc(lookup_pc),
		.hit(hit),
		.cache_word(cache_word),
		.request_valid(request_valid),
		.request(request),
		.request_taken(request_taken),
		.fill_valid(fill_valid),
		.fill(fill),
		.packet(packet),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	// request holds its cacheable form for as long as the pc stays in the window
	instruction_cache #(
		.CACHE_LINES(CACHE_LINES)
	) cache (
		.clock(clock),
		.reset(reset),
		.lookup(lookup),
		.lookup_pc(lookup_pc),
		.hit(hit),
		.cache_word(cache_word),
		.fill_valid(fill_valid),
		.fill(fill),
		.fill_enable(request.burst == burst_incrementing)
	);

	burst_reader reader (
		.clock(clock),
		.reset(reset),
		.request_valid(request_valid),
		.request(request),
		.request_taken(request_taken),
		.araddr(araddr),
		.arburst(arburst),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready),
		.fill_valid(fill_valid),
		.fill(fill)
	);

endmodule

`default_nettype wire

/* verilog/instruction_cache.sv */
`default_nettype none

module instruction_cache #(
	parameter int CACHE_LINES = 16
) (
	input logic clock,
	input logic reset,
	input logic lookup,
	input logic [31:0] lookup_pc,
	output logic hit,
	output logic [31:0] cache_word,
	input logic fill_valid,
	input fetch_pkg::cache_fill_t fill,
	input logic fill_enable
);
	import fetch_pkg::*;

	localparam int INDEX_BITS = $clog2(CACHE_LINES);
	localparam int WORD_BITS = $clog2(LINE_WORDS);
	localparam int OFFSET_BITS = WORD_BITS + 2;
	localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;

	logic [TAG_BITS-1:0] tag_array [CACHE_LINES];
	logic [31:0] data_array [CACHE_LINES * LINE_WORDS];
	logic [CACHE_LINES-1:0] line_valid;

	logic [INDEX_BITS-1:0] lookup_index;
	logic [INDEX_BITS+WORD_BITS-1:0] lookup_slot;
	logic [TAG_BITS-1:0] lookup_tag;
	logic [INDEX_BITS-1:0] fill_index;
	logic [INDEX_BITS+WORD_BITS-1:0] fill_slot;
	logic [TAG_BITS-1:0] fill_tag;
	logic fill_first;
	logic fill_write;

	logic [TAG_BITS-1:0] read_tag;
	logic [TAG_BITS-1:0] wanted_tag;
	logic read_valid;

	// data is addressed by word, so index and word offset form one slot number
	assign lookup_index = lookup_pc[OFFSET_BITS +: INDEX_BITS];
	assign lookup_slot = lookup_pc[2 +: INDEX_BITS + WORD_BITS];
	assign lookup_tag = lookup_pc[31 -: TAG_BITS];
	assign fill_index = fill.address[OFFSET_BITS +: INDEX_BITS];
	assign fill_slot = fill.address[2 +: INDEX_BITS + WORD_BITS];
	assign fill_tag = fill.address[31 -: TAG_BITS];
	assign fill_first = (fill.address[2 +: WORD_BITS] == '0);
	assign fill_write = fill_valid && fill_enable;

	assign hit = read_valid && (read_tag == wanted_tag);

	always_ff @(posedge clock) begin
		if (lookup) begin
			read_tag <= tag_array[lookup_index];
			wanted_tag <= lookup_tag;
			cache_word <= data_array[lookup_slot];
		end
		if (fill_write) begin
			data_array[fill_slot] <= fill.data;
			if (fill_first) tag_array[fill_index] <= fill_tag;
		end
	end

	// a line only becomes valid once its last beat is in, so a partial line never hits
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
			read_valid <= 1'b0;
		end else begin
			if (lookup) read_valid <= line_valid[lookup_index];
			if (fill_write) begin
				if (fill.last) begin
					line_valid[fill_index] <= 1'b1;
				end else if (fill_first) begin
					line_valid[fill_index] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire
